/* common/mc_pers_pkg.sv */
// shared widths and payload types for the MC adapter lanes
// MC request and response command codes
// atomic subcommand and exchange operand
// internal request kinds

package mc_pers_pkg;

	// lane count and field widths
	localparam int MC_PORTS   = 4;
	localparam int RTNCTL_W   = 32;
	localparam int TID_W      = 32;
	localparam int DATA_W     = 64;
	localparam int VADR_W     = 48;
	localparam int QW_BITS    = 3;
	localparam int MC_SIZE_W  = 2;
	localparam int MC_CMD_W   = 3;
	localparam int MC_SCMD_W  = 4;
	localparam int REQ_KIND_W = 2;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [VADR_W-1:0] vadr_t;

	// transaction tag
	// low QW_BITS hold quadword count minus one, the rest is the caller tag
	typedef logic [TID_W-1:0] tid_t;

	// caller tag with the quadword bits stripped off
	typedef logic [RTNCTL_W-QW_BITS-1:0] rsp_tag_t;

	// quadword count or index within a 64-byte line
	typedef logic [QW_BITS-1:0] qw_idx_t;

	typedef logic [MC_SIZE_W-1:0] mc_size_t;
	typedef logic [MC_CMD_W-1:0]  mc_cmd_t;
	typedef logic [MC_SCMD_W-1:0] mc_scmd_t;

	// request commands toward the MC
	localparam mc_cmd_t AEMC_CMD_RD8    = 3'd1;
	localparam mc_cmd_t AEMC_CMD_WR8    = 3'd2;
	localparam mc_cmd_t AEMC_CMD_ATOMIC = 3'd3;
	localparam mc_cmd_t AEMC_CMD_WR64   = 3'd5;
	localparam mc_cmd_t AEMC_CMD_RD64   = 3'd7;

	// response commands from the MC
	localparam mc_cmd_t MCAE_CMD_RD8_DATA    = 3'd2;
	localparam mc_cmd_t MCAE_CMD_WR_CMP      = 3'd3;
	localparam mc_cmd_t MCAE_CMD_ATOMIC_DATA = 3'd4;
	localparam mc_cmd_t MCAE_CMD_WR64_CMP    = 3'd6;
	localparam mc_cmd_t MCAE_CMD_RD64_DATA   = 3'd7;

	// atomic exchange subcommand
	localparam mc_scmd_t AEMC_SCMD_ATOM_EXCH = 4'd2;

	// operand sent in place of the caller data on an exchange
	localparam data_t ATOM_OPERAND = 64'h8000_0000_0000_0000;

	// request kinds from the personality
	typedef logic [REQ_KIND_W-1:0] req_kind_t;

	localparam req_kind_t REQ_READ        = 2'd0;
	localparam req_kind_t REQ_WRITE       = 2'd1;
	localparam req_kind_t REQ_ATOMIC      = 2'd2;
	localparam req_kind_t REQ_ATOMIC_EXCH = 2'd3;

endpackage

/* mc_adapter/mc_req_xlate.sv */
// request side of one MC lane
// maps an internal request onto MC request fields
// command picked from request kind and quadword count
// exchange operand substituted for atomic exchange
`timescale 1ns/1ps

module mc_req_xlate (
	// internal request
	input  logic                   i_req_vld,
	input  mc_pers_pkg::req_kind_t i_req_kind,
	input  mc_pers_pkg::mc_size_t  i_req_size,
	input  mc_pers_pkg::tid_t      i_req_tid,
	input  mc_pers_pkg::vadr_t     i_req_vadr,
	input  mc_pers_pkg::data_t     i_req_data,

	// MC request fields
	output logic                   o_mc_rq_vld,
	output mc_pers_pkg::tid_t      o_mc_rq_rtnctl,
	output mc_pers_pkg::data_t     o_mc_rq_data,
	output mc_pers_pkg::vadr_t     o_mc_rq_vadr,
	output mc_pers_pkg::mc_size_t  o_mc_rq_size,
	output mc_pers_pkg::mc_cmd_t   o_mc_rq_cmd,
	output mc_pers_pkg::mc_scmd_t  o_mc_rq_scmd
);

	import mc_pers_pkg::*;

	// quadword count minus one, carried in the low tag bits
	qw_idx_t qw_cnt;

	// single quadword access when the count bits are all zero
	logic    qw_single;

	// number of quadwords for a burst write, wraps at eight
	qw_idx_t wr64_qw_num;

	assign qw_cnt      = i_req_tid[QW_BITS-1:0];
	assign qw_single   = ~|qw_cnt;
	assign wr64_qw_num = qw_cnt + 1'b1;

	// straight pass-through fields
	assign o_mc_rq_vld    = i_req_vld;
	assign o_mc_rq_rtnctl = i_req_tid;
	assign o_mc_rq_vadr   = i_req_vadr;
	assign o_mc_rq_size   = i_req_size;

	// exchange always swaps in the fixed operand
	assign o_mc_rq_data = (i_req_kind == REQ_ATOMIC_EXCH) ? ATOM_OPERAND : i_req_data;

	// command select
	always_comb begin
		o_mc_rq_cmd = AEMC_CMD_ATOMIC;
		case (i_req_kind)
			REQ_READ: begin
				if (qw_single) begin
					o_mc_rq_cmd = AEMC_CMD_RD8;
				end else begin
					o_mc_rq_cmd = AEMC_CMD_RD64;
				end
			end
			REQ_WRITE: begin
				if (qw_single) begin
					o_mc_rq_cmd = AEMC_CMD_WR8;
				end else begin
					o_mc_rq_cmd = AEMC_CMD_WR64;
				end
			end
			// both atomic flavours share one MC command
			REQ_ATOMIC: begin
				o_mc_rq_cmd = AEMC_CMD_ATOMIC;
			end
			REQ_ATOMIC_EXCH: begin
				o_mc_rq_cmd = AEMC_CMD_ATOMIC;
			end
		endcase
	end

	// subcommand follows the chosen command
	always_comb begin
		case (o_mc_rq_cmd)
			// burst write carries its quadword count
			AEMC_CMD_WR64: begin
				o_mc_rq_scmd = mc_scmd_t'(wr64_qw_num);
			end
			AEMC_CMD_ATOMIC: begin
				o_mc_rq_scmd = AEMC_SCMD_ATOM_EXCH;
			end
			default: begin
				o_mc_rq_scmd = '0;
			end
		endcase
	end

endmodule

/* mc_adapter/mc_rsp_xlate.sv */
// response side of one MC lane
// splits MC responses into read returns and write completions
// unpacks caller tag and quadword index from the return control
// merges the consumer full levels into the MC response stall
`timescale 1ns/1ps

module mc_rsp_xlate (
	// MC response
	input  logic                  i_mc_rs_vld,
	input  mc_pers_pkg::mc_cmd_t  i_mc_rs_cmd,
	input  mc_pers_pkg::mc_scmd_t i_mc_rs_scmd,
	input  mc_pers_pkg::data_t    i_mc_rs_data,
	input  mc_pers_pkg::tid_t     i_mc_rs_rtnctl,

	// consumer levels
	input  logic                  i_rd_rsp_full,
	input  logic                  i_wr_rsp_full,

	// read return
	output logic                  o_rd_rsp_vld,
	output mc_pers_pkg::rsp_tag_t o_rd_rsp_tag,
	output mc_pers_pkg::qw_idx_t  o_rd_rsp_qw,
	output mc_pers_pkg::data_t    o_rd_rsp_data,

	// write completion
	output logic                  o_wr_rsp_vld,
	output mc_pers_pkg::tid_t     o_wr_rsp_tid,

	output logic                  o_mc_rs_stall
);

	import mc_pers_pkg::*;

	// response class decode
	logic is_rd_rsp;
	logic is_wr_rsp;

	// only a burst read return tells which quadword it is
	logic is_rd64;

	always_comb begin
		is_rd_rsp = 1'b0;
		is_wr_rsp = 1'b0;
		case (i_mc_rs_cmd)
			MCAE_CMD_RD8_DATA,
			MCAE_CMD_RD64_DATA,
			MCAE_CMD_ATOMIC_DATA: begin
				is_rd_rsp = 1'b1;
			end
			MCAE_CMD_WR_CMP,
			MCAE_CMD_WR64_CMP: begin
				is_wr_rsp = 1'b1;
			end
			default: begin
				is_rd_rsp = 1'b0;
				is_wr_rsp = 1'b0;
			end
		endcase
	end

	assign is_rd64 = (i_mc_rs_cmd == MCAE_CMD_RD64_DATA);

	// read return
	assign o_rd_rsp_vld  = i_mc_rs_vld & is_rd_rsp;
	assign o_rd_rsp_tag  = i_mc_rs_rtnctl[TID_W-1:QW_BITS];
	assign o_rd_rsp_qw   = is_rd64 ? i_mc_rs_scmd[QW_BITS-1:0] : '0;
	assign o_rd_rsp_data = i_mc_rs_data;

	// write completion keeps the whole tag
	assign o_wr_rsp_vld = i_mc_rs_vld & is_wr_rsp;
	assign o_wr_rsp_tid = i_mc_rs_rtnctl;

	// either consumer backing up holds off the MC
	assign o_mc_rs_stall = i_rd_rsp_full | i_wr_rsp_full;

endmodule

/* design/cae_pers.sv */
// personality top for the MC adapter
// one request and one response translator per MC lane
// request full mirrors the MC request stall of the same lane
`timescale 1ns/1ps

module cae_pers (
	// internal requests
	input  logic                   i_req_vld      [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::req_kind_t i_req_kind     [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::mc_size_t  i_req_size     [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::tid_t      i_req_tid      [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::vadr_t     i_req_vadr     [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::data_t     i_req_data     [mc_pers_pkg::MC_PORTS],
	output logic                   o_req_full     [mc_pers_pkg::MC_PORTS],

	// MC requests
	output logic                   o_mc_rq_vld    [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::tid_t      o_mc_rq_rtnctl [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::data_t     o_mc_rq_data   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::vadr_t     o_mc_rq_vadr   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::mc_size_t  o_mc_rq_size   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::mc_cmd_t   o_mc_rq_cmd    [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::mc_scmd_t  o_mc_rq_scmd   [mc_pers_pkg::MC_PORTS],
	input  logic                   i_mc_rq_stall  [mc_pers_pkg::MC_PORTS],

	// MC responses
	input  logic                   i_mc_rs_vld    [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::mc_cmd_t   i_mc_rs_cmd    [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::mc_scmd_t  i_mc_rs_scmd   [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::data_t     i_mc_rs_data   [mc_pers_pkg::MC_PORTS],
	input  mc_pers_pkg::tid_t      i_mc_rs_rtnctl [mc_pers_pkg::MC_PORTS],
	output logic                   o_mc_rs_stall  [mc_pers_pkg::MC_PORTS],

	// read returns
	output logic                   o_rd_rsp_vld   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::rsp_tag_t  o_rd_rsp_tag   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::qw_idx_t   o_rd_rsp_qw    [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::data_t     o_rd_rsp_data  [mc_pers_pkg::MC_PORTS],
	input  logic                   i_rd_rsp_full  [mc_pers_pkg::MC_PORTS],

	// write completions
	output logic                   o_wr_rsp_vld   [mc_pers_pkg::MC_PORTS],
	output mc_pers_pkg::tid_t      o_wr_rsp_tid   [mc_pers_pkg::MC_PORTS],
	input  logic                   i_wr_rsp_full  [mc_pers_pkg::MC_PORTS]
);

	import mc_pers_pkg::*;

	genvar lane;

	for (lane = 0; lane < MC_PORTS; lane++) begin : g_lane

		// MC request stall goes straight back to the requester
		assign o_req_full[lane] = i_mc_rq_stall[lane];

		mc_req_xlate u_req_xlate (
			.i_req_vld      (i_req_vld[lane]),
			.i_req_kind     (i_req_kind[lane]),
			.i_req_size     (i_req_size[lane]),
			.i_req_tid      (i_req_tid[lane]),
			.i_req_vadr     (i_req_vadr[lane]),
			.i_req_data     (i_req_data[lane]),
			.o_mc_rq_vld    (o_mc_rq_vld[lane]),
			.o_mc_rq_rtnctl (o_mc_rq_rtnctl[lane]),
			.o_mc_rq_data   (o_mc_rq_data[lane]),
			.o_mc_rq_vadr   (o_mc_rq_vadr[lane]),
			.o_mc_rq_size   (o_mc_rq_size[lane]),
			.o_mc_rq_cmd    (o_mc_rq_cmd[lane]),
			.o_mc_rq_scmd   (o_mc_rq_scmd[lane])
		);

		mc_rsp_xlate u_rsp_xlate (
			.i_mc_rs_vld    (i_mc_rs_vld[lane]),
			.i_mc_rs_cmd    (i_mc_rs_cmd[lane]),
			.i_mc_rs_scmd   (i_mc_rs_scmd[lane]),
			.i_mc_rs_data   (i_mc_rs_data[lane]),
			.i_mc_rs_rtnctl (i_mc_rs_rtnctl[lane]),
			.i_rd_rsp_full  (i_rd_rsp_full[lane]),
			.i_wr_rsp_full  (i_wr_rsp_full[lane]),
			.o_rd_rsp_vld   (o_rd_rsp_vld[lane]),
			.o_rd_rsp_tag   (o_rd_rsp_tag[lane]),
			.o_rd_rsp_qw    (o_rd_rsp_qw[lane]),
			.o_rd_rsp_data  (o_rd_rsp_data[lane]),
			.o_wr_rsp_vld   (o_wr_rsp_vld[lane]),
			.o_wr_rsp_tid   (o_wr_rsp_tid[lane]),
			.o_mc_rs_stall  (o_mc_rs_stall[lane])
		);

	end

endmodule

/* test/cae_pers_asserts.sv */
// concurrent checks on the MC adapter lanes
// response stall, exclusive response valids, request valid pass-through
`timescale 1ns/1ps

module cae_pers_asserts (
	input logic i_clk,
	input logic i_reset,
	input logic i_req_vld     [mc_pers_pkg::MC_PORTS],
	input logic i_mc_rq_vld   [mc_pers_pkg::MC_PORTS],
	input logic i_rd_rsp_full [mc_pers_pkg::MC_PORTS],
	input logic i_wr_rsp_full [mc_pers_pkg::MC_PORTS],
	input logic i_mc_rs_stall [mc_pers_pkg::MC_PORTS],
	input logic i_rd_rsp_vld  [mc_pers_pkg::MC_PORTS],
	input logic i_wr_rsp_vld  [mc_pers_pkg::MC_PORTS]
);

	import mc_pers_pkg::*;

	for (genvar lane = 0; lane < MC_PORTS; lane++) begin : g_lane

		// stall toward the MC is the OR of both consumer levels
		a_rs_stall: assert property (@(posedge i_clk) disable iff (i_reset)
			i_mc_rs_stall[lane] == (i_rd_rsp_full[lane] | i_wr_rsp_full[lane]))
		else $error("lane %0d: MC response stall does not follow the full levels", lane);

		// a response is either a read return or a write completion
		a_rsp_excl: assert property (@(posedge i_clk) disable iff (i_reset)
			!(i_rd_rsp_vld[lane] && i_wr_rsp_vld[lane]))
		else $error("lane %0d: read return and write completion valid together", lane);

		a_rq_vld: assert property (@(posedge i_clk) disable iff (i_reset)
			i_mc_rq_vld[lane] == i_req_vld[lane])
		else $error("lane %0d: MC request valid differs from request valid", lane);

	end

endmodule

/* test/tb_cae_pers.sv */
// directed testbench for the MC adapter top
// request command choice, atomics, read returns, write completions, back-pressure
// per-test result lines and a closing summary
`timescale 1ns/1ps

module tb_cae_pers;

	import mc_pers_pkg::*;

	localparam int   SETTLE_LIMIT  = 8;
	localparam int   WATCHDOG_CYC  = 5000;
	localparam data_t EXCH_OPERAND = 64'h8000_0000_0000_0000;

	logic clk;
	logic i_reset;

	logic      i_req_vld [MC_PORTS];
	req_kind_t i_req_kind [MC_PORTS];
	mc_size_t  i_req_size [MC_PORTS];
	tid_t      i_req_tid [MC_PORTS];
	vadr_t     i_req_vadr [MC_PORTS];
	data_t     i_req_data [MC_PORTS];
	logic      o_req_full [MC_PORTS];
	logic      o_mc_rq_vld [MC_PORTS];
	tid_t      o_mc_rq_rtnctl [MC_PORTS];
	data_t     o_mc_rq_data [MC_PORTS];
	vadr_t     o_mc_rq_vadr [MC_PORTS];
	mc_size_t  o_mc_rq_size [MC_PORTS];
	mc_cmd_t   o_mc_rq_cmd [MC_PORTS];
	mc_scmd_t  o_mc_rq_scmd [MC_PORTS];
	logic      i_mc_rq_stall [MC_PORTS];
	logic      i_mc_rs_vld [MC_PORTS];
	mc_cmd_t   i_mc_rs_cmd [MC_PORTS];
	mc_scmd_t  i_mc_rs_scmd [MC_PORTS];
	data_t     i_mc_rs_data [MC_PORTS];
	tid_t      i_mc_rs_rtnctl [MC_PORTS];
	logic      o_mc_rs_stall [MC_PORTS];
	logic      o_rd_rsp_vld [MC_PORTS];
	rsp_tag_t  o_rd_rsp_tag [MC_PORTS];
	qw_idx_t   o_rd_rsp_qw [MC_PORTS];
	data_t     o_rd_rsp_data [MC_PORTS];
	logic      i_rd_rsp_full [MC_PORTS];
	logic      o_wr_rsp_vld [MC_PORTS];
	tid_t      o_wr_rsp_tid [MC_PORTS];
	logic      i_wr_rsp_full [MC_PORTS];

	int errors;
	int checks;
	int tests_run;

	cae_pers dut_i (.*);

	bind cae_pers cae_pers_asserts u_asserts (
		.i_clk         (tb_cae_pers.clk),
		.i_reset       (tb_cae_pers.i_reset),
		.i_req_vld     (i_req_vld),
		.i_mc_rq_vld   (o_mc_rq_vld),
		.i_rd_rsp_full (i_rd_rsp_full),
		.i_wr_rsp_full (i_wr_rsp_full),
		.i_mc_rs_stall (o_mc_rs_stall),
		.i_rd_rsp_vld  (o_rd_rsp_vld),
		.i_wr_rsp_vld  (o_wr_rsp_vld)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare_field(input string test_name, input string field,
			input logic [63:0] exp_val, input logic [63:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			errors++;
			$display("** Error %s: %s expected %h, actual %h", test_name, field, exp_val, act_val);
		end
	endtask

	// which = 0 MC request, 1 read return, 2 write completion
	function automatic logic level_of(input int which, input int lane);
		case (which)
			0: return o_mc_rq_vld[lane];
			1: return o_rd_rsp_vld[lane];
			default: return o_wr_rsp_vld[lane];
		endcase
	endfunction

	task automatic wait_level(input string test_name, input string what,
			input int which, input int lane);
		int   steps;
		logic seen;
		seen = 1'b0;
		steps = 0;
		// must rise before the next rising clock edge
		while (!seen && steps < SETTLE_LIMIT) begin
			#1;
			seen = level_of(which, lane);
			steps++;
		end
		if (!seen) begin
			errors++;
			$display("%s: lane %0d timed out waiting for %s", test_name, lane, what);
		end
	endtask

	task automatic finish_test(input string test_name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: failed with %0d errors", test_name, errors - err_start);
		end
	endtask

	task automatic init_inputs();
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			i_req_vld[lane] = 1'b0;
			i_req_kind[lane] = REQ_READ;
			i_req_size[lane] = '0;
			i_req_tid[lane] = '0;
			i_req_vadr[lane] = '0;
			i_req_data[lane] = '0;
			i_mc_rq_stall[lane] = 1'b0;
			i_mc_rs_vld[lane] = 1'b0;
			i_mc_rs_cmd[lane] = '0;
			i_mc_rs_scmd[lane] = '0;
			i_mc_rs_data[lane] = '0;
			i_mc_rs_rtnctl[lane] = '0;
			i_rd_rsp_full[lane] = 1'b0;
			i_wr_rsp_full[lane] = 1'b0;
		end
	endtask

	task automatic idle_lanes();
		@(negedge clk);
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			i_req_vld[lane] = 1'b0;
			i_mc_rs_vld[lane] = 1'b0;
		end
	endtask

	// drive one request and compare every MC field against the command rules
	task automatic issue_and_check(input string test_name, input int lane,
			input req_kind_t kind, input tid_t tid);
		mc_cmd_t  exp_cmd;
		mc_scmd_t exp_scmd;
		data_t    exp_data;
		qw_idx_t  cnt;
		@(negedge clk);
		i_req_vld[lane] = 1'b1;
		i_req_kind[lane] = kind;
		i_req_size[lane] = mc_size_t'($urandom_range(3));
		i_req_tid[lane] = tid;
		i_req_vadr[lane] = vadr_t'({$urandom(), $urandom()});
		i_req_data[lane] = {$urandom(), $urandom()};
		cnt = tid[QW_BITS-1:0];
		exp_data = i_req_data[lane];
		exp_scmd = '0;
		if (kind == REQ_READ) begin
			exp_cmd = (cnt == 3'd0) ? AEMC_CMD_RD8 : AEMC_CMD_RD64;
		end else if (kind == REQ_WRITE) begin
			exp_cmd = (cnt == 3'd0) ? AEMC_CMD_WR8 : AEMC_CMD_WR64;
			if (cnt != 3'd0) begin
				exp_scmd = mc_scmd_t'(qw_idx_t'(cnt + 3'd1));
			end
		end else begin
			exp_cmd = AEMC_CMD_ATOMIC;
			exp_scmd = 4'd2;
			if (kind == REQ_ATOMIC_EXCH) begin
				exp_data = EXCH_OPERAND;
			end
		end
		wait_level(test_name, "MC request valid", 0, lane);
		compare_field(test_name, "cmd", 64'(exp_cmd), 64'(o_mc_rq_cmd[lane]));
		compare_field(test_name, "scmd", 64'(exp_scmd), 64'(o_mc_rq_scmd[lane]));
		compare_field(test_name, "data", exp_data, o_mc_rq_data[lane]);
		compare_field(test_name, "vadr", 64'(i_req_vadr[lane]), 64'(o_mc_rq_vadr[lane]));
		compare_field(test_name, "size", 64'(i_req_size[lane]), 64'(o_mc_rq_size[lane]));
		compare_field(test_name, "rtnctl", 64'(tid), 64'(o_mc_rq_rtnctl[lane]));
	endtask

	task automatic test_read_write_cmd();
		int   err_start;
		tid_t tid;
		err_start = errors;
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			for (int iter = 0; iter < 8; iter++) begin
				tid = $urandom();
				// every other tag is a single quadword
				if (iter % 2 == 0) begin
					tid[QW_BITS-1:0] = '0;
				end
				issue_and_check("read_write_cmd", lane, REQ_READ, tid);
				issue_and_check("read_write_cmd", lane, REQ_WRITE, tid);
			end
		end
		idle_lanes();
		finish_test("read_write_cmd", err_start);
	endtask

	task automatic test_atomics();
		int err_start;
		err_start = errors;
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			issue_and_check("atomics", lane, REQ_ATOMIC, $urandom());
			issue_and_check("atomics", lane, REQ_ATOMIC_EXCH, $urandom());
		end
		idle_lanes();
		finish_test("atomics", err_start);
	endtask

	task automatic drive_response(input int lane, input mc_cmd_t cmd, input logic vld);
		@(negedge clk);
		i_mc_rs_vld[lane] = vld;
		i_mc_rs_cmd[lane] = cmd;
		i_mc_rs_scmd[lane] = mc_scmd_t'($urandom_range(15));
		i_mc_rs_data[lane] = {$urandom(), $urandom()};
		i_mc_rs_rtnctl[lane] = $urandom();
	endtask

	task automatic test_read_returns();
		int      err_start;
		mc_cmd_t codes [3];
		qw_idx_t exp_qw;
		err_start = errors;
		codes = '{MCAE_CMD_RD8_DATA, MCAE_CMD_RD64_DATA, MCAE_CMD_ATOMIC_DATA};
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			foreach (codes[c]) begin
				drive_response(lane, codes[c], 1'b1);
				exp_qw = (codes[c] == 3'd7) ? i_mc_rs_scmd[lane][2:0] : 3'd0;
				wait_level("read_returns", "read return valid", 1, lane);
				compare_field("read_returns", "wr_vld", 64'd0, 64'(o_wr_rsp_vld[lane]));
				compare_field("read_returns", "tag", 64'(i_mc_rs_rtnctl[lane] >> 3),
					64'(o_rd_rsp_tag[lane]));
				compare_field("read_returns", "qw", 64'(exp_qw), 64'(o_rd_rsp_qw[lane]));
				compare_field("read_returns", "data", i_mc_rs_data[lane], o_rd_rsp_data[lane]);
			end
		end
		idle_lanes();
		finish_test("read_returns", err_start);
	endtask

	task automatic test_write_completions();
		int      err_start;
		mc_cmd_t other [3];
		err_start = errors;
		other = '{3'd0, 3'd1, 3'd5};
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			drive_response(lane, MCAE_CMD_WR_CMP, 1'b1);
			wait_level("write_completions", "write completion valid", 2, lane);
			compare_field("write_completions", "tid", 64'(i_mc_rs_rtnctl[lane]),
				64'(o_wr_rsp_tid[lane]));
			drive_response(lane, MCAE_CMD_WR64_CMP, 1'b1);
			wait_level("write_completions", "write completion valid", 2, lane);
			compare_field("write_completions", "tid", 64'(i_mc_rs_rtnctl[lane]),
				64'(o_wr_rsp_tid[lane]));
			compare_field("write_completions", "rd_vld", 64'd0, 64'(o_rd_rsp_vld[lane]));
			// codes that are neither class
			foreach (other[c]) begin
				drive_response(lane, other[c], 1'b1);
				#1;
				compare_field("write_completions", "rd_vld", 64'd0, 64'(o_rd_rsp_vld[lane]));
				compare_field("write_completions", "wr_vld", 64'd0, 64'(o_wr_rsp_vld[lane]));
			end
			// idle response with a read code
			drive_response(lane, MCAE_CMD_RD8_DATA, 1'b0);
			#1;
			compare_field("write_completions", "rd_vld", 64'd0, 64'(o_rd_rsp_vld[lane]));
			compare_field("write_completions", "wr_vld", 64'd0, 64'(o_wr_rsp_vld[lane]));
		end
		idle_lanes();
		finish_test("write_completions", err_start);
	endtask

	task automatic test_back_pressure();
		int err_start;
		err_start = errors;
		for (int lane = 0; lane < MC_PORTS; lane++) begin
			for (int c = 0; c < 4; c++) begin
				@(negedge clk);
				i_rd_rsp_full[lane] = c[0];
				i_wr_rsp_full[lane] = c[1];
				#1;
				compare_field("back_pressure", "rs_stall", 64'(c[0] | c[1]),
					64'(o_mc_rs_stall[lane]));
			end
			@(negedge clk);
			i_rd_rsp_full[lane] = 1'b0;
			i_wr_rsp_full[lane] = 1'b0;
			i_mc_rq_stall[lane] = 1'b1;
			#1;
			for (int j = 0; j < MC_PORTS; j++) begin
				compare_field("back_pressure", "req_full", 64'(j == lane), 64'(o_req_full[j]));
			end
			@(negedge clk);
			i_mc_rq_stall[lane] = 1'b0;
			#1;
			compare_field("back_pressure", "req_full", 64'd0, 64'(o_req_full[lane]));
		end
		finish_test("back_pressure", err_start);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		tests_run = 0;
		void'($urandom(32'hc621_88e0));
		i_reset = 1'b1;
		init_inputs();
		repeat (16) @(negedge clk);
		i_reset = 1'b0;
		test_read_write_cmd();
		test_atomics();
		test_read_returns();
		test_write_completions();
		test_back_pressure();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// guard against a stalled run
	initial begin
		for (int c = 0; c < WATCHDOG_CYC; c++) begin
			@(posedge clk);
		end
		$display("watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* flist.f */
common/mc_pers_pkg.sv
mc_adapter/mc_req_xlate.sv
mc_adapter/mc_rsp_xlate.sv
design/cae_pers.sv
test/cae_pers_asserts.sv
test/tb_cae_pers.sv

/* Makefile */
# Verilator build for the MC adapter testbench

TOP := tb_cae_pers

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q -F '*** FAILED ***' sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q -F '*** PASSED ***' sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
